// ==== all.f ====
verilog/ninjin_pkg.sv
verilog/ninjin_ddr_ctrl.sv
verilog/ninjin_m_axi_image.sv
verilog/ninjin_image_buf.sv
verilog/ninjin_image_top.sv
testbench/axi_slave_mem.sv
testbench/test_ninjin.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ninjin image mover testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module test_ninjin -f all.f -o sim_ninjin \
  || { echo "build failed"; exit 1; }
./obj_dir/sim_ninjin > sim.log 2>&1
cat sim.log
grep -q "^sim passed$" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

// ==== testbench/test_ninjin.sv ====
`timescale 1ns/100ps

module test_ninjin
  import ninjin_pkg::*;
();

  localparam int BURST_MAX   = 256;
  localparam int BUF_WORDS   = 1024;
  localparam logic [31:0] ERR_BASE = 32'h0000_3000;
  localparam int TOTAL_WORDS = 16 + 37 + 4 + 1 + 4 + 1 + 2 * BURST_MAX;
  localparam int LIMIT       = 40 * TOTAL_WORDS + 2000;

  logic clk, xrst, start, mode;
  logic [WORDSIZE+LSB-1:0] base;
  logic [MEMSIZE-1:0] len;
  logic [WORDSIZE-1:0] buf_base;
  logic busy, done;
  logic [3:0] err;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  logic [31:0] awaddr, wdata, araddr, rdata;
  logic [7:0] awlen, arlen;
  logic [2:0] awsize, arsize;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;
  logic core_en, core_we;
  logic [WORDSIZE-1:0] core_addr;
  logic [BWIDTH-1:0] core_wdata, core_rdata;

  // expectations for the transfer in flight
  logic [3:0]  exp_err;
  int          exp_len;
  logic [31:0] exp_addr;
  int          w_buf;
  int          w_beat;
  logic [31:0] fill_mem [BUF_WORDS];
  logic        chk_en, chk_d;
  logic [31:0] chk_exp, chk_exp_d;
  logic [15:0] rnd_state;
  int          cycles, starts, dones;

  ninjin_image_top #(.BURST_MAX(BURST_MAX), .BUF_WORDS(BUF_WORDS)) i_ninjin_image_top (.*);

  axi_slave_mem #(.ERR_BASE(ERR_BASE)) i_slave_mem (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error %s got %h expected %h", name, got, exp);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
      abort_run("timeout, transfers did not finish in time");
  end

  //========================================
  // checkers
  //========================================

  always @(posedge clk) begin
    chk_d     <= core_en && !core_we && chk_en;
    chk_exp_d <= chk_exp;
    if (done)
      dones <= dones + 1;
    if (start)
      w_beat <= 0;
    else if (wvalid && wready)
      w_beat <= w_beat + 1;
  end

  a_core_data: assert property (@(posedge clk) disable iff (!xrst)
    chk_d |-> core_rdata == chk_exp_d)
    else report_mismatch("core_rdata", core_rdata, chk_exp_d);
  a_wdata: assert property (@(posedge clk) disable iff (!xrst)
    (wvalid && wready) |-> wdata == fill_mem[w_buf + w_beat])
    else report_mismatch("wdata", wdata, fill_mem[w_buf + w_beat]);
  a_wlast: assert property (@(posedge clk) disable iff (!xrst)
    (wvalid && wready) |-> wlast == (w_beat == exp_len - 1))
    else report_mismatch("wlast", 32'(wlast), 32'(w_beat == exp_len - 1));
  // every lane of a full word beat
  a_wstrb: assert property (@(posedge clk) disable iff (!xrst)
    wvalid |-> wstrb == 4'hf)
    else report_mismatch("wstrb", 32'(wstrb), 32'h0000000f);
  a_awlen: assert property (@(posedge clk) disable iff (!xrst)
    awvalid |-> awlen == 8'(exp_len - 1))
    else report_mismatch("awlen", 32'(awlen), 32'(exp_len - 1));
  a_awaddr: assert property (@(posedge clk) disable iff (!xrst)
    awvalid |-> awaddr == exp_addr)
    else report_mismatch("awaddr", awaddr, exp_addr);
  // four bytes per beat
  a_awsize: assert property (@(posedge clk) disable iff (!xrst)
    awvalid |-> awsize == 3'd2)
    else report_mismatch("awsize", 32'(awsize), 32'd2);
  a_arlen: assert property (@(posedge clk) disable iff (!xrst)
    arvalid |-> arlen == 8'(exp_len - 1))
    else report_mismatch("arlen", 32'(arlen), 32'(exp_len - 1));
  a_araddr: assert property (@(posedge clk) disable iff (!xrst)
    arvalid |-> araddr == exp_addr)
    else report_mismatch("araddr", araddr, exp_addr);
  a_arsize: assert property (@(posedge clk) disable iff (!xrst)
    arvalid |-> arsize == 3'd2)
    else report_mismatch("arsize", 32'(arsize), 32'd2);
  a_err: assert property (@(posedge clk) disable iff (!xrst)
    done |-> err == exp_err)
    else report_mismatch("err", 32'(err), 32'(exp_err));
  a_busy_rise: assert property (@(posedge clk) disable iff (!xrst)
    (start && !busy) |=> busy)
    else abort_run("busy did not rise after start");
  a_busy_fall: assert property (@(posedge clk) disable iff (!xrst)
    $fell(busy) |-> done)
    else abort_run("busy fell without done");
  a_done_pulse: assert property (@(posedge clk) disable iff (!xrst)
    done |=> !done)
    else abort_run("done longer than one cycle");
  a_aw_stable: assert property (@(posedge clk) disable iff (!xrst)
    (awvalid && !awready) |=> awvalid && $stable(awaddr) && $stable(awlen))
    else abort_run("AW channel changed before awready");
  a_w_stable: assert property (@(posedge clk) disable iff (!xrst)
    (wvalid && !wready) |=> wvalid && $stable(wdata) && $stable(wlast))
    else abort_run("W channel changed before wready");
  a_ar_stable: assert property (@(posedge clk) disable iff (!xrst)
    (arvalid && !arready) |=> arvalid && $stable(araddr) && $stable(arlen))
    else abort_run("AR channel changed before arready");

  //========================================
  // stimulus
  //========================================

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_rand_word(output logic [31:0] word);
    for (int k = 0; k < 32; k++) begin
      rnd_state = lfsr_step(rnd_state);
      word[k] = rnd_state[0];
    end
  endtask

  task automatic fill_buffer(input int addr, input int n);
    logic [31:0] word;
    for (int k = 0; k < n; k++) begin
      next_rand_word(word);
      fill_mem[addr + k] = word;
      @(posedge clk);
      core_en    <= 1'b1;
      core_we    <= 1'b1;
      core_addr  <= WORDSIZE'(addr + k);
      core_wdata <= word;
    end
    @(posedge clk);
    core_en <= 1'b0;
    core_we <= 1'b0;
  endtask

  // buffer words against the host preset rule
  task automatic check_buffer(input int addr, input int host_word, input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      core_en   <= 1'b1;
      core_addr <= WORDSIZE'(addr + k);
      chk_en    <= 1'b1;
      chk_exp   <= 32'(host_word + k) ^ 32'h5a5a0000;
    end
    @(posedge clk);
    core_en <= 1'b0;
    chk_en  <= 1'b0;
    @(posedge clk);
  endtask

  task automatic check_host(input int host_word, input int addr, input int n);
    for (int k = 0; k < n; k++)
      assert (i_slave_mem.mem[host_word + k] == fill_mem[addr + k])
        else report_mismatch("host mem", i_slave_mem.mem[host_word + k], fill_mem[addr + k]);
  endtask

  task automatic transfer(input logic dir, input int host_word, input int n,
                          input int addr, input logic [3:0] err_v);
    exp_len  = n;
    exp_err  = err_v;
    exp_addr = 32'(host_word) << LSB;
    w_buf    = addr;
    starts   = starts + 1;
    @(posedge clk);
    start    <= 1'b1;
    mode     <= dir;
    base     <= (WORDSIZE+LSB)'(host_word << LSB);
    len      <= MEMSIZE'(n);
    buf_base <= WORDSIZE'(addr);
    @(posedge clk);
    start <= 1'b0;
    do
      @(negedge clk);
    while (!done);
    // done and err are sampled on this edge
    @(posedge clk);
  endtask

  initial begin
    xrst = 1'b0;
    start = 1'b0;
    mode = 1'b0;
    base = '0;
    len = '0;
    buf_base = '0;
    core_en = 1'b0;
    core_we = 1'b0;
    core_addr = '0;
    core_wdata = '0;
    chk_en = 1'b0;
    chk_exp = '0;
    exp_err = 4'b0000;
    exp_len = 1;
    exp_addr = '0;
    w_buf = 0;
    cycles = 0;
    starts = 0;
    dones = 0;
    rnd_state = 16'd5978;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
    @(negedge clk);
    assert (!busy && !done && !awvalid && !arvalid && !wvalid && !bready && !rready
            && !i_ninjin_image_top.ddr_req && !i_ninjin_image_top.ddr_we)
      else abort_run("outputs not idle after reset");

    transfer(DDR_READ, 'h010, 16, 'h000, 4'b0000);
    check_buffer('h000, 'h010, 16);
    fill_buffer('h100, 37);
    transfer(DDR_WRITE, 'h200, 37, 'h100, 4'b0000);
    check_host('h200, 'h100, 37);

    // error region, then a clean single word to clear err
    transfer(DDR_WRITE, 'hc00, 4, 'h100, 4'b1010);
    transfer(DDR_READ, 'h050, 1, 'h020, 4'b0000);
    check_buffer('h020, 'h050, 1);
    transfer(DDR_READ, 'hc10, 4, 'h3f0, 4'b0110);
    fill_buffer('h030, 1);
    transfer(DDR_WRITE, 'h060, 1, 'h030, 4'b0000);
    check_host('h060, 'h030, 1);

    // full length bursts
    transfer(DDR_READ, 'h400, BURST_MAX, 'h200, 4'b0000);
    check_buffer('h200, 'h400, BURST_MAX);
    fill_buffer('h300, BURST_MAX);
    transfer(DDR_WRITE, 'h800, BURST_MAX, 'h300, 4'b0000);
    check_host('h800, 'h300, BURST_MAX);

    repeat (4) @(posedge clk);
    if (dones == starts) begin
      $display("sim passed");
      $finish;
    end
    else begin
      $display("done count %0d does not match start count %0d", dones, starts);
      $display("sim failed");
      $fatal(1);
    end
  end

endmodule

// ==== testbench/axi_slave_mem.sv ====
`timescale 1ns/100ps

module axi_slave_mem #(
  parameter logic [31:0] ERR_BASE = 32'h0000_3000
) (
  input               clk,
  input               xrst,
  input               awvalid,
  output logic        awready,
  input        [31:0] awaddr,
  input               wvalid,
  output logic        wready,
  input        [31:0] wdata,
  input               wlast,
  output logic        bvalid,
  input               bready,
  output logic [1:0]  bresp,
  input               arvalid,
  output logic        arready,
  input        [31:0] araddr,
  input        [7:0]  arlen,
  output logic        rvalid,
  input               rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rlast
);

  logic [31:0] mem [4096];
  logic [15:0] lfsr;
  logic        wr_active;
  logic        b_pending;
  logic        wr_err;
  logic [11:0] wr_addr;
  logic        rd_active;
  logic        rd_err;
  logic [11:0] rd_addr;
  logic [7:0]  rd_cnt;
  logic [7:0]  rd_len;

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
  function automatic logic [15:0] lfsr_advance(input logic [15:0] s, input int n);
    logic [15:0] t;
    t = s;
    for (int k = 0; k < n; k++)
      t = {t[14:0], t[15] ^ t[13] ^ t[12] ^ t[10]};
    return t;
  endfunction

  // five fresh bits each cycle, one per stalled signal
  always_ff @(posedge clk)
    if (!xrst)
      lfsr <= 16'd5978;
    else
      lfsr <= lfsr_advance(lfsr, 5);

  assign awready = !wr_active && !b_pending && lfsr[0];
  assign wready  = wr_active && lfsr[1];
  assign arready = !rd_active && !rvalid && lfsr[2];

  //========================================
  // write channels
  //========================================

  always_ff @(posedge clk)
    if (!xrst) begin
      for (int i = 0; i < 4096; i++)
        mem[i] <= 32'(i) ^ 32'h5a5a0000;
    end
    else if (wvalid && wready && !wr_err)
      mem[wr_addr] <= wdata;

  always_ff @(posedge clk)
    if (!xrst) begin
      wr_active <= 1'b0;
      b_pending <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= 2'b00;
    end
    else begin
      if (awvalid && awready) begin
        wr_active <= 1'b1;
        wr_addr   <= awaddr[13:2];
        wr_err    <= awaddr >= ERR_BASE;
      end
      if (wvalid && wready) begin
        wr_addr <= wr_addr + 12'd1;
        if (wlast) begin
          wr_active <= 1'b0;
          b_pending <= 1'b1;
        end
      end
      if (b_pending && !bvalid && lfsr[3]) begin
        bvalid <= 1'b1;
        bresp  <= wr_err ? 2'b10 : 2'b00;
      end
      else if (bvalid && bready) begin
        bvalid    <= 1'b0;
        b_pending <= 1'b0;
      end
    end

  //========================================
  // read channels
  //========================================

  always_ff @(posedge clk)
    if (!xrst) begin
      rd_active <= 1'b0;
      rvalid    <= 1'b0;
      rlast     <= 1'b0;
      rresp     <= 2'b00;
    end
    else begin
      if (arvalid && arready) begin
        rd_active <= 1'b1;
        rd_addr   <= araddr[13:2];
        rd_len    <= arlen;
        rd_cnt    <= 8'd0;
        rd_err    <= araddr >= ERR_BASE;
      end
      else if (rd_active && !rvalid && lfsr[4]) begin
        rvalid <= 1'b1;
        rdata  <= mem[rd_addr];
        rlast  <= rd_cnt == rd_len;
        rresp  <= rd_err ? 2'b10 : 2'b00;
      end
      else if (rvalid && rready) begin
        rvalid  <= 1'b0;
        rd_addr <= rd_addr + 12'd1;
        rd_cnt  <= rd_cnt + 8'd1;
        if (rlast)
          rd_active <= 1'b0;
      end
    end

endmodule

// ==== verilog/ninjin_image_top.sv ====
`timescale 1ns/100ps

module ninjin_image_top
  import ninjin_pkg::*;
 #( parameter int BURST_MAX = 256
  , parameter int BUF_WORDS = 1024
  )
  ( input                       clk
  , input                       xrst
  // host command
  , input                       start
  , input                       mode
  , input  [WORDSIZE+LSB-1:0]   base
  , input  [MEMSIZE-1:0]        len
  , input  [WORDSIZE-1:0]       buf_base
  , output                      busy
  , output                      done
  , output [3:0]                err
  // AXI master
  , output                      awvalid
  , input                       awready
  , output [BWIDTH-1:0]         awaddr
  , output [7:0]                awlen
  , output [2:0]                awsize
  , output                      wvalid
  , input                       wready
  , output [BWIDTH-1:0]         wdata
  , output [BWIDTH/8-1:0]       wstrb
  , output                      wlast
  , input                       bvalid
  , output                      bready
  , input  [1:0]                bresp
  , output                      arvalid
  , input                       arready
  , output [BWIDTH-1:0]         araddr
  , output [7:0]                arlen
  , output [2:0]                arsize
  , input                       rvalid
  , output                      rready
  , input  [BWIDTH-1:0]         rdata
  , input  [1:0]                rresp
  , input                       rlast
  // core side of the buffer
  , input                       core_en
  , input                       core_we
  , input  [WORDSIZE-1:0]       core_addr
  , input  [BWIDTH-1:0]         core_wdata
  , output [BWIDTH-1:0]         core_rdata
  );

  logic                    ddr_req;
  logic                    ddr_mode;
  logic [WORDSIZE+LSB-1:0] ddr_base;
  logic [MEMSIZE-1:0]      ddr_len;
  logic [WORDSIZE-1:0]     ddr_buf;
  logic                    ddr_ack;
  logic [3:0]              axi_err;
  logic                    ddr_we;
  logic [WORDSIZE-1:0]     ddr_waddr;
  logic [BWIDTH-1:0]       ddr_wdata;
  logic [WORDSIZE-1:0]     ddr_raddr;
  logic [BWIDTH-1:0]       ddr_rdata;

  ninjin_ddr_ctrl #(.BURST_MAX(BURST_MAX), .BUF_WORDS(BUF_WORDS)) i_ddr_ctrl (
    .clk, .xrst, .start, .mode, .base, .len, .buf_base, .ddr_ack, .axi_err,
    .busy, .done, .err, .ddr_req, .ddr_mode, .ddr_base, .ddr_len, .ddr_buf
  );

  ninjin_m_axi_image #(.BURST_MAX(BURST_MAX)) i_m_axi_image (
    .clk, .xrst, .ddr_req, .ddr_mode, .ddr_base, .ddr_len, .ddr_buf, .ddr_rdata,
    .awready, .wready, .bvalid, .bresp, .arready, .rvalid, .rdata, .rresp, .rlast,
    .ddr_ack, .err(axi_err), .awvalid, .awaddr, .awlen, .awsize,
    .wvalid, .wdata, .wstrb, .wlast, .bready, .arvalid, .araddr, .arlen, .arsize,
    .rready, .ddr_we, .ddr_waddr, .ddr_wdata, .ddr_raddr
  );

  ninjin_image_buf #(.BUF_WORDS(BUF_WORDS)) i_image_buf (
    .clk, .ddr_we, .ddr_waddr, .ddr_wdata, .ddr_raddr,
    .core_en, .core_we, .core_addr, .core_wdata, .ddr_rdata, .core_rdata
  );

endmodule

// ==== verilog/ninjin_image_buf.sv ====
`timescale 1ns/100ps

module ninjin_image_buf
  import ninjin_pkg::*;
 #( parameter int BUF_WORDS = 1024
  )
  ( input                       clk
  , input                       ddr_we
  , input        [WORDSIZE-1:0] ddr_waddr
  , input        [BWIDTH-1:0]   ddr_wdata
  , input        [WORDSIZE-1:0] ddr_raddr
  , input                       core_en
  , input                       core_we
  , input        [WORDSIZE-1:0] core_addr
  , input        [BWIDTH-1:0]   core_wdata
  , output logic [BWIDTH-1:0]   ddr_rdata
  , output logic [BWIDTH-1:0]   core_rdata
  );

  localparam int AW = clogb2(BUF_WORDS - 1);

  logic [BWIDTH-1:0] mem [BUF_WORDS];

  // mover side, write from AXI reads and registered read for AXI writes
  // core side shares the same array
  always_ff @(posedge clk) begin
    if (ddr_we)
      mem[ddr_waddr[AW-1:0]] <= ddr_wdata;
    if (core_en && core_we)
      mem[core_addr[AW-1:0]] <= core_wdata;
    ddr_rdata <= mem[ddr_raddr[AW-1:0]];
    if (core_en)
      core_rdata <= mem[core_addr[AW-1:0]];
  end

  a_no_clash: assert property (@(posedge clk)
    !(ddr_we && core_en && core_we && ddr_waddr[AW-1:0] == core_addr[AW-1:0]))
    else $error("image_buf: core and mover write %h together", core_addr);

endmodule

// ==== verilog/ninjin_m_axi_image.sv ====
`timescale 1ns/100ps

module ninjin_m_axi_image
  import ninjin_pkg::*;
 #( parameter int BURST_MAX = 256
  )
  ( input                           clk
  , input                           xrst
  , input                           ddr_req
  , input                           ddr_mode
  , input        [WORDSIZE+LSB-1:0] ddr_base
  , input        [MEMSIZE-1:0]      ddr_len
  , input        [WORDSIZE-1:0]     ddr_buf
  , input        [BWIDTH-1:0]       ddr_rdata
  , input                           awready
  , input                           wready
  , input                           bvalid
  , input        [1:0]              bresp
  , input                           arready
  , input                           rvalid
  , input        [BWIDTH-1:0]       rdata
  , input        [1:0]              rresp
  , input                           rlast
  , output logic                    ddr_ack
  , output logic [3:0]              err
  , output logic                    awvalid
  , output logic [BWIDTH-1:0]       awaddr
  , output logic [7:0]              awlen
  , output logic [2:0]              awsize
  , output logic                    wvalid
  , output logic [BWIDTH-1:0]       wdata
  , output logic [BWIDTH/8-1:0]     wstrb
  , output logic                    wlast
  , output logic                    bready
  , output logic                    arvalid
  , output logic [BWIDTH-1:0]       araddr
  , output logic [7:0]              arlen
  , output logic [2:0]              arsize
  , output logic                    rready
  , output logic                    ddr_we
  , output logic [WORDSIZE-1:0]     ddr_waddr
  , output logic [BWIDTH-1:0]       ddr_wdata
  , output logic [WORDSIZE-1:0]     ddr_raddr
  );

  localparam int       TXN_W = clogb2(BURST_MAX);
  localparam bit [2:0] SIZE  = 3'(clogb2(BWIDTH/8 - 1));

  typedef enum logic {S_IDLE, S_BUSY} state_t;

  state_t             state_write;
  state_t             state_read;
  logic               req_d;
  logic               req_pulse;
  logic               wreq_pulse;
  logic               rreq_pulse;
  logic               aw_done;
  logic [TXN_W-1:0]   wr_len;
  logic [TXN_W-1:0]   wr_last;
  logic [TXN_W-1:0]   rd_cnt;
  logic [TXN_W-1:0]   w_cnt;
  logic               rd_fire;
  logic               rd_inflight;
  logic [1:0]         occ;
  logic               pf_valid;
  logic [BWIDTH-1:0]  pf_data;
  logic               wnext;
  logic               out_free;
  logic               load_out;
  logic               load_pf;
  logic               b_fire;
  logic [TXN_W-1:0]   rd_last;
  logic [TXN_W-1:0]   r_cnt;
  logic               r_fire;
  logic               read_end;
  logic               err_wresp;
  logic               err_rresp;

//========================================
// request edge and state machines
//========================================

  assign req_pulse  = ddr_req && !req_d;
  assign wreq_pulse = req_pulse && ddr_mode == DDR_WRITE;
  assign rreq_pulse = req_pulse && ddr_mode == DDR_READ;

  assign b_fire   = bvalid && bready;
  assign r_fire   = rvalid && rready;
  assign read_end = r_fire && r_cnt == rd_last;

  always_ff @(posedge clk)
    if (!xrst)
      req_d <= 1'b0;
    else
      req_d <= ddr_req;

  // write and read directions run on their own
  always_ff @(posedge clk)
    if (!xrst)
      state_write <= S_IDLE;
    else if (state_write == S_IDLE && wreq_pulse)
      state_write <= S_BUSY;
    else if (state_write == S_BUSY && b_fire)
      state_write <= S_IDLE;

  always_ff @(posedge clk)
    if (!xrst)
      state_read <= S_IDLE;
    else if (state_read == S_IDLE && rreq_pulse)
      state_read <= S_BUSY;
    else if (state_read == S_BUSY && read_end)
      state_read <= S_IDLE;

  always_ff @(posedge clk)
    if (!xrst)
      ddr_ack <= 1'b0;
    else
      ddr_ack <= (state_write == S_BUSY && b_fire) || (state_read == S_BUSY && read_end);

//========================================
// write address
//========================================

  assign awsize = SIZE;

  always_ff @(posedge clk)
    if (!xrst) begin
      awvalid <= 1'b0;
      aw_done <= 1'b0;
    end
    else if (wreq_pulse) begin
      awvalid <= 1'b1;
      aw_done <= 1'b0;
    end
    else if (awvalid && awready) begin
      awvalid <= 1'b0;
      aw_done <= 1'b1;
    end

  always_ff @(posedge clk)
    if (wreq_pulse) begin
      awaddr  <= BWIDTH'(ddr_base);
      awlen   <= 8'(ddr_len - MEMSIZE'(1));
      wr_len  <= TXN_W'(ddr_len);
      wr_last <= TXN_W'(ddr_len - MEMSIZE'(1));
    end

//========================================
// buffer read and write data
//========================================

  assign wstrb    = '1;
  assign wnext    = wvalid && wready;
  assign out_free = !wvalid || wnext;
  assign wlast    = wvalid && w_cnt == wr_last;

  // words held after this cycle, wdata plus prefetch plus the one in flight
  assign occ = {1'b0, wvalid} + {1'b0, pf_valid} + {1'b0, rd_inflight} - {1'b0, wnext};

  // only issue when the returning word is sure to find a slot
  assign rd_fire = state_write == S_BUSY && aw_done && rd_cnt != wr_len && occ <= 2'd1;

  assign load_out = out_free && (pf_valid || rd_inflight);
  assign load_pf  = rd_inflight && (pf_valid || !out_free);

  always_ff @(posedge clk)
    if (!xrst)
      rd_inflight <= 1'b0;
    else
      rd_inflight <= rd_fire;

  always_ff @(posedge clk)
    if (wreq_pulse)
      ddr_raddr <= ddr_buf;
    else if (rd_fire)
      ddr_raddr <= ddr_raddr + WORDSIZE'(1);

  always_ff @(posedge clk)
    if (!xrst) begin
      rd_cnt <= '0;
      w_cnt  <= '0;
    end
    else if (wreq_pulse) begin
      rd_cnt <= '0;
      w_cnt  <= '0;
    end
    else begin
      if (rd_fire)
        rd_cnt <= rd_cnt + TXN_W'(1);
      if (wnext)
        w_cnt <= w_cnt + TXN_W'(1);
    end

  always_ff @(posedge clk)
    if (!xrst) begin
      wvalid   <= 1'b0;
      pf_valid <= 1'b0;
    end
    else begin
      if (load_out)
        wvalid <= 1'b1;
      else if (wnext)
        wvalid <= 1'b0;
      if (load_pf)
        pf_valid <= 1'b1;
      else if (out_free)
        pf_valid <= 1'b0;
    end

  // prefetch goes out first, it is the older word
  always_ff @(posedge clk) begin
    if (load_out)
      wdata <= pf_valid ? pf_data : ddr_rdata;
    if (load_pf)
      pf_data <= ddr_rdata;
  end

//========================================
// write response
//========================================

  assign err_wresp = b_fire && bresp[1];

  always_ff @(posedge clk)
    if (!xrst)
      bready <= 1'b0;
    else if (bvalid && !bready)
      bready <= 1'b1;
    else
      bready <= 1'b0;

//========================================
// read address and data
//========================================

  assign arsize    = SIZE;
  assign err_rresp = r_fire && rresp[1];

  always_ff @(posedge clk)
    if (!xrst)
      arvalid <= 1'b0;
    else if (rreq_pulse)
      arvalid <= 1'b1;
    else if (arvalid && arready)
      arvalid <= 1'b0;

  always_ff @(posedge clk)
    if (rreq_pulse) begin
      araddr  <= BWIDTH'(ddr_base);
      arlen   <= 8'(ddr_len - MEMSIZE'(1));
      rd_last <= TXN_W'(ddr_len - MEMSIZE'(1));
    end

  always_ff @(posedge clk)
    if (!xrst)
      rready <= 1'b0;
    else if (rreq_pulse)
      rready <= 1'b0;
    else if (state_read == S_BUSY && rvalid) begin
      if (rlast && rready)
        rready <= 1'b0;
      else
        rready <= 1'b1;
    end

  always_ff @(posedge clk)
    if (!xrst)
      r_cnt <= '0;
    else if (rreq_pulse)
      r_cnt <= '0;
    else if (r_fire)
      r_cnt <= r_cnt + TXN_W'(1);

  // each R beat becomes one buffer write a cycle later
  always_ff @(posedge clk)
    if (!xrst)
      ddr_we <= 1'b0;
    else
      ddr_we <= r_fire;

  always_ff @(posedge clk) begin
    if (r_fire)
      ddr_wdata <= rdata;
    if (rreq_pulse)
      ddr_waddr <= ddr_buf;
    else if (ddr_we)
      ddr_waddr <= ddr_waddr + WORDSIZE'(1);
  end

  always_ff @(posedge clk)
    if (!xrst)
      err <= 4'b0000;
    else if (req_pulse)
      err <= 4'b0000;
    else if (err_wresp || err_rresp)
      err <= err | {err_wresp, err_rresp, 1'b1, 1'b0};

  a_aw_hold: assert property (@(posedge clk) disable iff (!xrst)
    (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
    else $error("m_axi: awvalid dropped before awready");

  // nothing more leaves after the len-th beat
  a_wlast_end: assert property (@(posedge clk) disable iff (!xrst)
    (wnext && wlast) |=> (w_cnt == wr_len && !wvalid))
    else $error("m_axi: wlast not on beat %0d", wr_len);

endmodule

// ==== verilog/ninjin_ddr_ctrl.sv ====
`timescale 1ns/100ps

module ninjin_ddr_ctrl
  import ninjin_pkg::*;
 #( parameter int BURST_MAX = 256
  , parameter int BUF_WORDS = 1024
  )
  ( input                         clk
  , input                         xrst
  , input                         start
  , input                         mode
  , input        [WORDSIZE+LSB-1:0] base
  , input        [MEMSIZE-1:0]    len
  , input        [WORDSIZE-1:0]   buf_base
  , input                         ddr_ack
  , input        [3:0]            axi_err
  , output logic                  busy
  , output logic                  done
  , output logic [3:0]            err
  , output logic                  ddr_req
  , output logic                  ddr_mode
  , output logic [WORDSIZE+LSB-1:0] ddr_base
  , output logic [MEMSIZE-1:0]    ddr_len
  , output logic [WORDSIZE-1:0]   ddr_buf
  );

  logic accept;

  // starts while busy are dropped
  assign accept = start && !busy;

  always_ff @(posedge clk)
    if (!xrst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      ddr_req <= 1'b0;
      err     <= 4'b0000;
    end
    else begin
      done <= 1'b0;
      if (accept) begin
        busy    <= 1'b1;
        ddr_req <= 1'b1;
        err     <= 4'b0000;
      end
      else if (busy && ddr_ack) begin
        busy    <= 1'b0;
        ddr_req <= 1'b0;
        done    <= 1'b1;
        err     <= axi_err;
      end
    end

  // command held stable while the request is up
  always_ff @(posedge clk)
    if (accept) begin
      ddr_mode <= mode;
      ddr_base <= base;
      ddr_len  <= len;
      ddr_buf  <= buf_base;
    end

  a_len_range: assert property (@(posedge clk) disable iff (!xrst)
    accept |-> (len >= MEMSIZE'(1) && int'(len) <= BURST_MAX))
    else $error("ddr_ctrl: len %0d out of burst range", len);

  a_buf_range: assert property (@(posedge clk) disable iff (!xrst)
    accept |-> (int'(buf_base) + int'(len) <= BUF_WORDS))
    else $error("ddr_ctrl: buffer window %0d+%0d overflows", buf_base, len);

endmodule

// ==== verilog/ninjin_pkg.sv ====
package ninjin_pkg;

  //========================================
  // word and address widths
  //========================================

  // data bus and buffer word
  localparam int BWIDTH   = 32;
  // byte offset bits inside one word
  localparam int LSB      = 2;
  // word address into host space and buffer
  localparam int WORDSIZE = 12;
  // transfer word count, holds up to 256
  localparam int MEMSIZE  = 9;

  //========================================
  // direction codes
  //========================================

  // read is host to buffer, write is buffer to host
  localparam logic DDR_READ  = 1'b0;
  localparam logic DDR_WRITE = 1'b1;

  // number of bits needed to hold value
  function automatic int clogb2(input int value);
    int bits;
    int rest;
    bits = 0;
    rest = value;
    while (rest > 0) begin
      bits = bits + 1;
      rest = rest >> 1;
    end
    return bits;
  endfunction

endpackage
